// File: Makefile
TOP = isp_top_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module isp_top

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

// File: rtl/color_correction.sv
`default_nettype none

module color_correction #(
    parameter int CC_FRAC_BITS = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_valid,
    input  isp_pixel_pkg::rgb_pixel_t  in_pixel,
    input  isp_config_pkg::cc_matrix_t matrix,
    output logic                       out_valid,
    output isp_pixel_pkg::rgb_pixel_t  out_pixel
);

    import isp_pixel_pkg::*;
    import isp_config_pkg::*;

    // zero-extended component times a coefficient, plus two carry bits for the sum
    localparam int OPND_WIDTH = PIXEL_WIDTH + 1;
    localparam int SUM_WIDTH  = OPND_WIDTH + COEFF_WIDTH + 2;

    rgb_pixel_t corrected;

    // one matrix row applied to the input pixel
    function automatic pixel_t apply_row(
        input rgb_pixel_t px,
        input coeff_t     k_red,
        input coeff_t     k_green,
        input coeff_t     k_blue
    );
        logic signed [OPND_WIDTH-1:0] red_s;
        logic signed [OPND_WIDTH-1:0] green_s;
        logic signed [OPND_WIDTH-1:0] blue_s;
        logic signed [SUM_WIDTH-1:0]  sum;
        logic signed [SUM_WIDTH-1:0]  shifted;

        // inputs are unsigned, keep them positive
        red_s   = {1'b0, px.red};
        green_s = {1'b0, px.green};
        blue_s  = {1'b0, px.blue};

        sum = red_s * k_red + green_s * k_green + blue_s * k_blue;

        // arithmetic shift rounds toward minus infinity
        shifted = sum >>> CC_FRAC_BITS;

        // negative result clamps to zero
        if (shifted[SUM_WIDTH-1]) begin
            return '0;
        end
        // overflow above the pixel range
        if (|shifted[SUM_WIDTH-2:PIXEL_WIDTH]) begin
            return PIXEL_MAX;
        end
        return shifted[PIXEL_WIDTH-1:0];
    endfunction

    // rows in order red, green, blue
    always_comb begin
        corrected.red   = apply_row(in_pixel, matrix[0], matrix[1], matrix[2]);
        corrected.green = apply_row(in_pixel, matrix[3], matrix[4], matrix[5]);
        corrected.blue  = apply_row(in_pixel, matrix[6], matrix[7], matrix[8]);
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_pixel <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                out_pixel <= corrected;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/frame_writer.sv
`default_nettype none

module frame_writer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      new_frame,
    input  isp_config_pkg::addr_t     frame_base_addr,
    input  logic                      pixel_valid,
    input  isp_pixel_pkg::rgb_pixel_t pixel,
    output logic                      write_enable,
    output isp_config_pkg::addr_t     write_address,
    output isp_config_pkg::mem_word_t write_data
);

    import isp_pixel_pkg::*;
    import isp_config_pkg::*;

    // unused low bits of the memory word
    localparam int PAD_WIDTH = MEM_DATA_WIDTH - 3 * PIXEL_WIDTH;

    // every finished pixel is written in its own cycle
    assign write_enable = pixel_valid;

    // red, green, blue from the top, zero padding below
    assign write_data = {pixel, {PAD_WIDTH{1'b0}}};

    // address of the current write
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            write_address <= '0;
        end else if (new_frame) begin
            // frame start wins over a write in the same cycle
            write_address <= frame_base_addr;
        end else if (pixel_valid) begin
            write_address <= write_address + ADDR_WIDTH'(1);
        end
    end

endmodule

`default_nettype wire

// File: rtl/isp_config_pkg.sv
`default_nettype none

package isp_config_pkg;

    localparam int GAIN_WIDTH     = 16;
    localparam int COEFF_WIDTH    = 16;
    localparam int ADDR_WIDTH     = 32;
    localparam int MEM_DATA_WIDTH = 64;

    // unsigned gain, binary point given by the white balance parameter
    typedef logic [GAIN_WIDTH-1:0] gain_t;

    // two's complement coefficient, binary point given by the matrix parameter
    typedef logic signed [COEFF_WIDTH-1:0] coeff_t;

    // per-channel gain and black level
    typedef struct packed {
        gain_t                 gain_red;
        gain_t                 gain_green;
        gain_t                 gain_blue;
        isp_pixel_pkg::pixel_t black_red;
        isp_pixel_pkg::pixel_t black_green;
        isp_pixel_pkg::pixel_t black_blue;
    } wb_config_t;

    // element 3*row + col
    // row 0 produces red, col 0 weights the red input
    typedef coeff_t [8:0] cc_matrix_t;

    // frame buffer interface
    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [MEM_DATA_WIDTH-1:0] mem_word_t;

endpackage

`default_nettype wire

// File: rtl/isp_pixel_pkg.sv
`default_nettype none

package isp_pixel_pkg;

    // bits per colour component
    localparam int PIXEL_WIDTH = 16;

    // one unsigned colour component
    typedef logic [PIXEL_WIDTH-1:0] pixel_t;

    // saturation level for every stage
    localparam pixel_t PIXEL_MAX = '1;

    // demosaiced pixel, red in the top bits
    typedef struct packed {
        pixel_t red;
        pixel_t green;
        pixel_t blue;
    } rgb_pixel_t;

endpackage

`default_nettype wire

// File: rtl/isp_top.sv
`default_nettype none

module isp_top #(
    parameter int WB_FRAC_BITS = 8,
    parameter int CC_FRAC_BITS = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       pixel_valid,
    input  isp_pixel_pkg::rgb_pixel_t  pixel_in,
    input  logic                       new_frame,
    input  isp_config_pkg::addr_t      frame_base_addr,
    input  isp_config_pkg::wb_config_t wb_config,
    input  isp_config_pkg::cc_matrix_t cc_matrix,
    output logic                       write_enable,
    output isp_config_pkg::addr_t      write_address,
    output isp_config_pkg::mem_word_t  write_data
);

    import isp_pixel_pkg::*;

    // white balance to colour correction
    logic       wb_valid;
    rgb_pixel_t wb_pixel;

    // colour correction to frame writer
    logic       cc_valid;
    rgb_pixel_t cc_pixel;

    // first stage, one cycle
    white_balance #(
        .WB_FRAC_BITS (WB_FRAC_BITS)
    ) u_white_balance (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (pixel_valid),
        .in_pixel  (pixel_in),
        .wb_config (wb_config),
        .out_valid (wb_valid),
        .out_pixel (wb_pixel)
    );

    // second stage, one cycle
    color_correction #(
        .CC_FRAC_BITS (CC_FRAC_BITS)
    ) u_color_correction (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (wb_valid),
        .in_pixel  (wb_pixel),
        .matrix    (cc_matrix),
        .out_valid (cc_valid),
        .out_pixel (cc_pixel)
    );

    // write path is combinational, so the write lands two cycles after the strobe
    frame_writer u_frame_writer (
        .clk             (clk),
        .reset           (reset),
        .new_frame       (new_frame),
        .frame_base_addr (frame_base_addr),
        .pixel_valid     (cc_valid),
        .pixel           (cc_pixel),
        .write_enable    (write_enable),
        .write_address   (write_address),
        .write_data      (write_data)
    );

endmodule

`default_nettype wire

// File: rtl/white_balance.sv
`default_nettype none

module white_balance #(
    parameter int WB_FRAC_BITS = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_valid,
    input  isp_pixel_pkg::rgb_pixel_t  in_pixel,
    input  isp_config_pkg::wb_config_t wb_config,
    output logic                       out_valid,
    output isp_pixel_pkg::rgb_pixel_t  out_pixel
);

    import isp_pixel_pkg::*;
    import isp_config_pkg::*;

    // full product of a component and a gain
    localparam int PROD_WIDTH = PIXEL_WIDTH + GAIN_WIDTH;

    rgb_pixel_t balanced;

    // black level removal, gain and saturation for one component
    function automatic pixel_t balance(
        input pixel_t value,
        input pixel_t black,
        input gain_t  gain
    );
        pixel_t                lifted;
        logic [PROD_WIDTH-1:0] product;
        logic [PROD_WIDTH-1:0] scaled;

        // black level above the sample gives zero
        lifted  = (value > black) ? value - black : '0;
        product = lifted * gain;
        scaled  = product >> WB_FRAC_BITS;

        // anything left above the pixel range saturates
        if (|scaled[PROD_WIDTH-1:PIXEL_WIDTH]) begin
            return PIXEL_MAX;
        end
        return scaled[PIXEL_WIDTH-1:0];
    endfunction

    always_comb begin
        balanced.red   = balance(in_pixel.red, wb_config.black_red,
                                 wb_config.gain_red);
        balanced.green = balance(in_pixel.green, wb_config.black_green,
                                 wb_config.gain_green);
        balanced.blue  = balance(in_pixel.blue, wb_config.black_blue,
                                 wb_config.gain_blue);
    end

    // single pipeline stage
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_pixel <= '0;
        end else begin
            out_valid <= in_valid;
            // pixel holds between strobes
            if (in_valid) begin
                out_pixel <= balanced;
            end
        end
    end

endmodule

`default_nettype wire

// File: src.f
rtl/isp_pixel_pkg.sv
rtl/isp_config_pkg.sv
rtl/white_balance.sv
rtl/color_correction.sv
rtl/frame_writer.sv
rtl/isp_top.sv
tb/tb_clock_gen.sv
tb/isp_top_tb.sv

// File: tb/isp_top_tb.sv
`default_nettype none

module isp_top_tb;

    import isp_pixel_pkg::*;
    import isp_config_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int DRIVE_DELAY  = 2;
    localparam int RANDOM_SEED  = 53823;

    // fixed-point formats of the DUT
    localparam int WB_FRAC = 8;
    localparam int CC_FRAC = 8;

    localparam longint PIXEL_LIMIT = longint'(PIXEL_MAX);

    localparam int IDENTITY_PIXELS = 32;
    localparam int RANDOM_SETS     = 8;
    localparam int SET_PIXELS      = 48;
    localparam int ADDRESS_PIXELS  = 20;
    localparam int MAX_GAP         = 3;

    // each strobe costs at most MAX_GAP idle cycles plus its own, each drain a few more
    localparam int STIMULUS_CYCLES = RESET_CYCLES
        + (IDENTITY_PIXELS + RANDOM_SETS * SET_PIXELS + ADDRESS_PIXELS) * (MAX_GAP + 1)
        + (RANDOM_SETS + 8) * 8;
    localparam int WATCHDOG_CYCLES = STIMULUS_CYCLES + 100;

    logic       clk;
    logic       reset;
    logic       pixel_valid;
    rgb_pixel_t pixel_in;
    logic       new_frame;
    addr_t      frame_base_addr;
    wb_config_t wb_config;
    cc_matrix_t cc_matrix;
    logic       write_enable;
    addr_t      write_address;
    mem_word_t  write_data;

    // expected memory words in strobe order
    mem_word_t expected_words[$];
    addr_t     model_addr;
    logic      valid_d1;
    logic      valid_d2;
    string     test_name;

    tb_clock_gen #(
        .PERIOD        (CLK_PERIOD),
        .RESET_CYCLES  (RESET_CYCLES),
        .RELEASE_DELAY (DRIVE_DELAY)
    ) clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    isp_top #(
        .WB_FRAC_BITS (WB_FRAC),
        .CC_FRAC_BITS (CC_FRAC)
    ) UUT (
        .clk             (clk),
        .reset           (reset),
        .pixel_valid     (pixel_valid),
        .pixel_in        (pixel_in),
        .new_frame       (new_frame),
        .frame_base_addr (frame_base_addr),
        .wb_config       (wb_config),
        .cc_matrix       (cc_matrix),
        .write_enable    (write_enable),
        .write_address   (write_address),
        .write_data      (write_data)
    );

    task automatic fail_value(input string check, input logic [63:0] expected,
                              input logic [63:0] actual);
        $display("Error in %s, %s: expected %h actual %h", test_name, check, expected, actual);
        $display("TB FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic fail_plain(input string reason);
        $display("%s, during %s", reason, test_name);
        $display("TB FAILED");
        $fatal(1, "check failed");
    endtask

    // black level removal with underflow to zero, then gain and saturation
    function automatic longint balanced_value(input longint value, input longint black,
                                              input longint gain);
        longint level;
        longint scaled;
        level  = (value > black) ? value - black : longint'(0);
        scaled = (level * gain) >>> WB_FRAC;
        return (scaled > PIXEL_LIMIT) ? PIXEL_LIMIT : scaled;
    endfunction

    // one matrix row, floor of the scaled sum, clamped to the pixel range
    function automatic longint corrected_value(input longint r, input longint g,
                                               input longint b, input longint k_r,
                                               input longint k_g, input longint k_b);
        longint total;
        longint scaled;
        total  = r * k_r + g * k_g + b * k_b;
        scaled = total >>> CC_FRAC;
        if (scaled < longint'(0)) begin
            return longint'(0);
        end
        return (scaled > PIXEL_LIMIT) ? PIXEL_LIMIT : scaled;
    endfunction

    // memory word for a pixel under the current configuration
    function automatic mem_word_t model_word(input rgb_pixel_t px);
        longint wb_r;
        longint wb_g;
        longint wb_b;
        longint out_r;
        longint out_g;
        longint out_b;
        wb_r = balanced_value(longint'(px.red), longint'(wb_config.black_red),
                              longint'(wb_config.gain_red));
        wb_g = balanced_value(longint'(px.green), longint'(wb_config.black_green),
                              longint'(wb_config.gain_green));
        wb_b = balanced_value(longint'(px.blue), longint'(wb_config.black_blue),
                              longint'(wb_config.gain_blue));
        out_r = corrected_value(wb_r, wb_g, wb_b, longint'(cc_matrix[0]),
                                longint'(cc_matrix[1]), longint'(cc_matrix[2]));
        out_g = corrected_value(wb_r, wb_g, wb_b, longint'(cc_matrix[3]),
                                longint'(cc_matrix[4]), longint'(cc_matrix[5]));
        out_b = corrected_value(wb_r, wb_g, wb_b, longint'(cc_matrix[6]),
                                longint'(cc_matrix[7]), longint'(cc_matrix[8]));
        return {pixel_t'(out_r), pixel_t'(out_g), pixel_t'(out_b), 16'h0000};
    endfunction

    function automatic rgb_pixel_t random_pixel();
        rgb_pixel_t px;
        px.red   = pixel_t'($urandom());
        px.green = pixel_t'($urandom());
        px.blue  = pixel_t'($urandom());
        return px;
    endfunction

    // strobes and frame pulses last one cycle unless driven again
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
        pixel_valid = 1'b0;
        new_frame   = 1'b0;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) next_cycle();
    endtask

    task automatic send_pixel(input rgb_pixel_t px, input mem_word_t word);
        next_cycle();
        pixel_valid = 1'b1;
        pixel_in    = px;
        expected_words.push_back(word);
    endtask

    task automatic send_after_gap(input rgb_pixel_t px);
        idle(int'($urandom_range(0, MAX_GAP)));
        send_pixel(px, model_word(px));
    endtask

    task automatic start_frame(input addr_t base);
        next_cycle();
        new_frame       = 1'b1;
        frame_base_addr = base;
    endtask

    task automatic wait_drained();
        while (expected_words.size() != 0) begin
            next_cycle();
        end
    endtask

    // configuration only changes with the pipeline empty
    task automatic load_config(input wb_config_t wb, input cc_matrix_t m);
        wait_drained();
        next_cycle();
        wb_config = wb;
        cc_matrix = m;
    endtask

    task automatic load_random_config();
        wb_config_t wb;
        cc_matrix_t m;
        wb.gain_red    = gain_t'($urandom_range(64, 1024));
        wb.gain_green  = gain_t'($urandom_range(64, 1024));
        wb.gain_blue   = gain_t'($urandom_range(64, 1024));
        wb.black_red   = pixel_t'($urandom_range(0, 8192));
        wb.black_green = pixel_t'($urandom_range(0, 8192));
        wb.black_blue  = pixel_t'($urandom_range(0, 8192));
        // coefficients between -2.0 and +2.0
        for (int i = 0; i < 9; i++) begin
            m[i] = coeff_t'(int'($urandom_range(0, 1024)) - 512);
        end
        load_config(wb, m);
    endtask

    // write monitor, sampled on the edge before the DUT moves on
    always @(posedge clk) begin
        mem_word_t expected_word;
        if (reset) begin
            assert (write_enable == 1'b0)
                else fail_value("write_enable", 64'd0, 64'(write_enable));
            assert (write_address == '0)
                else fail_value("write_address", 64'd0, 64'(write_address));
            model_addr = '0;
            valid_d1   = 1'b0;
            valid_d2   = 1'b0;
        end else begin
            assert (write_enable == valid_d2)
                else fail_value("write_enable", 64'(valid_d2), 64'(write_enable));
            assert (write_address == model_addr)
                else fail_value("write_address", 64'(model_addr), 64'(write_address));
            if (write_enable) begin
                assert (expected_words.size() > 0)
                    else fail_plain("A write appeared with no pixel in flight");
                expected_word = expected_words.pop_front();
                assert (write_data == expected_word)
                    else fail_value("write_data", expected_word, write_data);
            end
            // a frame start overrides the increment of a write in the same cycle
            if (new_frame) begin
                model_addr = frame_base_addr;
            end else if (write_enable) begin
                model_addr = model_addr + 32'd1;
            end
            valid_d2 = valid_d1;
            valid_d1 = pixel_valid;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the tests never finished", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        wb_config_t wb;
        cc_matrix_t m;
        rgb_pixel_t px;

        pixel_valid     = 1'b0;
        pixel_in        = '0;
        new_frame       = 1'b0;
        frame_base_addr = '0;
        wb_config       = '0;
        cc_matrix       = '0;
        test_name       = "reset";
        void'($urandom(RANDOM_SEED));

        @(negedge reset);
        idle(3);

        test_name      = "identity";
        wb.gain_red    = gain_t'(1 << WB_FRAC);
        wb.gain_green  = gain_t'(1 << WB_FRAC);
        wb.gain_blue   = gain_t'(1 << WB_FRAC);
        wb.black_red   = '0;
        wb.black_green = '0;
        wb.black_blue  = '0;
        m    = '0;
        m[0] = coeff_t'(1 << CC_FRAC);
        m[4] = coeff_t'(1 << CC_FRAC);
        m[8] = coeff_t'(1 << CC_FRAC);
        load_config(wb, m);
        send_pixel('0, '0);
        send_pixel('1, {48'hffff_ffff_ffff, 16'h0000});
        for (int i = 2; i < IDENTITY_PIXELS; i++) begin
            px = random_pixel();
            idle(int'($urandom_range(0, MAX_GAP)));
            send_pixel(px, {px, 16'h0000});
        end

        // underflow, gain saturation, negative row and overflowing row
        test_name      = "corner arithmetic";
        wb.gain_red    = gain_t'(1 << WB_FRAC);
        wb.gain_green  = 16'hffff;
        wb.gain_blue   = gain_t'(1 << WB_FRAC);
        wb.black_red   = 16'h8000;
        wb.black_green = '0;
        wb.black_blue  = '0;
        m    = '0;
        m[0] = coeff_t'(1 << CC_FRAC);
        m[4] = coeff_t'(-(1 << CC_FRAC));
        m[6] = 16'sh7fff;
        m[7] = 16'sh7fff;
        m[8] = 16'sh7fff;
        load_config(wb, m);
        for (int i = 0; i < SET_PIXELS; i++) begin
            send_after_gap(random_pixel());
        end

        test_name = "random arithmetic";
        for (int set = 1; set < RANDOM_SETS; set++) begin
            load_random_config();
            for (int i = 0; i < SET_PIXELS; i++) begin
                send_after_gap(random_pixel());
            end
        end

        test_name = "addressing";
        wait_drained();
        start_frame(32'h2000_0000);
        for (int i = 0; i < 5; i++) begin
            px = random_pixel();
            send_pixel(px, model_word(px));
        end
        idle(5);
        for (int i = 0; i < 3; i++) begin
            send_after_gap(random_pixel());
        end
        wait_drained();
        idle(4);
        // second frame pulse lands on the cycle of the first write
        px = random_pixel();
        send_pixel(px, model_word(px));
        px = random_pixel();
        send_pixel(px, model_word(px));
        start_frame(32'h3000_0100);
        for (int i = 0; i < 4; i++) begin
            send_after_gap(random_pixel());
        end

        // no stray write may follow the last one
        test_name = "write count";
        wait_drained();
        idle(4);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD        = 20,
    parameter int RESET_CYCLES  = 10,
    parameter int RELEASE_DELAY = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset drops just after the last reset edge, like any other input
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #RELEASE_DELAY;
        reset = 1'b0;
    end

endmodule

`default_nettype wire
